// ==== branch_unit.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module branch_unit (
   input  logic [`ID_NB_REG-1:0] i_rdata_a,
   input  logic [`ID_NB_REG-1:0] i_rdata_b,
   input  logic                  i_fwd_sel_a,
   input  logic [`ID_NB_REG-1:0] i_fwd_data_a,
   input  logic                  i_fwd_sel_b,
   input  logic [`ID_NB_REG-1:0] i_fwd_data_b,
   input  logic                  i_is_branch,
   input  logic                  i_branch_ne,
   input  logic                  i_jump_rs,
   input  logic                  i_jump_inm,
   output logic                  o_branch_taken,
   output logic                  o_squash
);

   logic [`ID_NB_REG-1:0] op_a;
   logic [`ID_NB_REG-1:0] op_b;
   logic                  equal;

   // Forwarded values from later stages win over the register file
   assign op_a = i_fwd_sel_a ? i_fwd_data_a : i_rdata_a;
   assign op_b = i_fwd_sel_b ? i_fwd_data_b : i_rdata_b;

   assign equal = (op_a == op_b);

   assign o_branch_taken = i_is_branch & (i_branch_ne ^ equal);

   // Any change of flow kills the instruction behind it
   assign o_squash = o_branch_taken | i_jump_rs | i_jump_inm;

endmodule

// ==== func_decoder.sv ====
`timescale 1ns/1ps

module func_decoder
   import id_pkg::*;
   (
   input  func_e   i_func,
   output alu_op_e o_alu_op,
   output logic    o_use_shamt,
   output logic    o_link_pc,
   output logic    o_jump_rs
   );

   always_comb begin
      o_alu_op    = ADD;
      o_use_shamt = 1'b0;
      o_link_pc   = 1'b0;
      o_jump_rs   = 1'b0;
      case (i_func)
         // Shift by immediate amount
         FUNC_SLL: begin
            o_alu_op    = SLL;
            o_use_shamt = 1'b1;
         end
         FUNC_SRL: begin
            o_alu_op    = SRL;
            o_use_shamt = 1'b1;
         end
         FUNC_SRA: begin
            o_alu_op    = SRA;
            o_use_shamt = 1'b1;
         end
         // Shift amount from rs
         FUNC_SLLV: o_alu_op = SLL;
         FUNC_SRLV: o_alu_op = SRL;
         FUNC_SRAV: o_alu_op = SRA;
         FUNC_ADDU: o_alu_op = ADD;
         FUNC_SUBU: o_alu_op = SUB;
         FUNC_AND:  o_alu_op = AND;
         FUNC_OR:   o_alu_op = OR;
         FUNC_XOR:  o_alu_op = XOR;
         FUNC_NOR:  o_alu_op = NOR;
         FUNC_SLT:  o_alu_op = SLT;
         FUNC_JR:   o_jump_rs = 1'b1;
         FUNC_JALR: begin
            o_jump_rs = 1'b1;
            o_link_pc = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// ==== id_config.svh ====
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Datapath widths
`define ID_NB_REG       32
`define ID_NB_REG_ADDR  5
`define ID_REG_DEPTH    32
`define ID_NB_INM       16
`define ID_NB_SHAMT     5
`define ID_NB_J_INM     26
`define ID_NB_OPCODE    6

// Top bit of each instruction field
`define ID_MSB_OPCODE   31
`define ID_MSB_RS       25
`define ID_MSB_RT       20
`define ID_MSB_RD       15
`define ID_MSB_SHAMT    10
`define ID_MSB_FUNC     5
`define ID_MSB_INM      15

// Link register for JAL
`define ID_RA_ADDR      5'd31

`endif

// ==== id_ctrl_if.sv ====
`timescale 1ns/1ps

interface id_ctrl_if
   import id_pkg::*;
   (
   input logic i_clk
   );

   ex_ctrl_t  ex;
   mem_ctrl_t mem;
   wb_ctrl_t  wb;
   logic      is_r_type;
   logic      is_branch;
   logic      branch_ne;
   logic      jump_rs;
   logic      jump_inm;

   // Decoder side
   modport dec (
      input  i_clk,
      output ex, mem, wb,
      output is_r_type, is_branch, branch_ne, jump_rs, jump_inm
   );

   // Pipeline register side
   modport regs (
      input ex, mem, wb,
      input is_r_type, is_branch, branch_ne, jump_rs, jump_inm
   );

endinterface

// ==== id_pipe_regs.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module id_pipe_regs
   import id_pkg::*;
   (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic                       i_valid,
   id_ctrl_if.regs                    ctrl,
   input  logic                       i_squash,
   input  logic [`ID_NB_REG-1:0]      i_a,
   input  logic [`ID_NB_REG-1:0]      i_b,
   input  logic [`ID_NB_REG-1:0]      i_pc,
   input  logic [`ID_NB_INM-1:0]      i_inm,
   input  logic [`ID_NB_SHAMT-1:0]    i_shamt,
   output ex_ctrl_t                   o_ex_ctrl,
   output mem_ctrl_t                  o_mem_ctrl,
   output wb_ctrl_t                   o_wb_ctrl,
   output logic [`ID_NB_REG-1:0]      o_a,
   output logic [`ID_NB_REG-1:0]      o_b,
   output logic [`ID_NB_REG-1:0]      o_pc,
   output logic [`ID_NB_INM-1:0]      o_inm,
   output logic [`ID_NB_SHAMT-1:0]    o_shamt,
   output logic                       o_nop
   );

   // Held while the stage is frozen
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
         o_a        <= '0;
         o_b        <= '0;
         o_nop      <= 1'b0;
      end else if (i_valid) begin
         o_ex_ctrl  <= ctrl.ex;
         o_mem_ctrl <= ctrl.mem;
         o_wb_ctrl  <= ctrl.wb;
         o_a        <= i_a;
         o_b        <= i_b;
         o_nop      <= i_squash;
      end
   end

   // Free running
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_pc    <= '0;
         o_inm   <= '0;
         o_shamt <= '0;
      end else begin
         o_pc    <= i_pc;
         o_inm   <= i_inm;
         o_shamt <= i_shamt;
      end
   end

   a_nop_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_nop)
      else $error("nop set right after reset");

endmodule

// ==== id_pkg.sv ====
`include "id_config.svh"

package id_pkg;

   ////////////////////////////////////////////////////////////
   // Instruction encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [`ID_NB_OPCODE-1:0] {
      R_INST = 6'b000000,
      LB     = 6'b100000,
      LH     = 6'b100001,
      LW     = 6'b100011,
      LBU    = 6'b100100,
      LHU    = 6'b100101,
      LWU    = 6'b100111,
      SB     = 6'b101000,
      SH     = 6'b101001,
      SW     = 6'b101011,
      ADDI   = 6'b001001,
      ANDI   = 6'b001100,
      ORI    = 6'b001101,
      XORI   = 6'b001110,
      LUI    = 6'b001111,
      SLTI   = 6'b001010,
      BEQ    = 6'b000100,
      BNE    = 6'b000101,
      J      = 6'b000010,
      JAL    = 6'b000011,
      HLT    = 6'b111111
   } opcode_e;

   // R-type function field
   typedef enum logic [`ID_NB_OPCODE-1:0] {
      FUNC_SLL  = 6'b000000,
      FUNC_SRL  = 6'b000010,
      FUNC_SRA  = 6'b000011,
      FUNC_SLLV = 6'b000100,
      FUNC_SRLV = 6'b000110,
      FUNC_SRAV = 6'b000111,
      FUNC_JR   = 6'b001000,
      FUNC_JALR = 6'b001001,
      FUNC_ADDU = 6'b100001,
      FUNC_SUBU = 6'b100011,
      FUNC_AND  = 6'b100100,
      FUNC_OR   = 6'b100101,
      FUNC_XOR  = 6'b100110,
      FUNC_NOR  = 6'b100111,
      FUNC_SLT  = 6'b101010
   } func_e;

   typedef enum logic [3:0] {
      ADD = 4'd0, SUB = 4'd1, AND = 4'd2, OR = 4'd3,
      XOR = 4'd4, NOR = 4'd5, SRL = 4'd6, SLL = 4'd7,
      SRA = 4'd8, SLA = 4'd9, SLT = 4'd10, LUI_OP = 4'd11
   } alu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } mem_size_e;

   ////////////////////////////////////////////////////////////
   // Control bundles passed to EX, MEM and WB
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      alu_op_e alu_op;
      logic    imm_sel;
      logic    unsigned_imm;
      logic    use_shamt;
   } ex_ctrl_t;

   typedef struct packed {
      logic      rd_en;
      logic      wr_en;
      logic      unsigned_ld;
      mem_size_e size;
   } mem_ctrl_t;

   typedef struct packed {
      logic [`ID_NB_REG_ADDR-1:0] dest;
      logic                       reg_we;
      logic                       from_alu;
      logic                       link_pc;
   } wb_ctrl_t;

endpackage

// ==== id_stage.f ====
+incdir+.
id_pkg.sv
id_ctrl_if.sv
func_decoder.sv
main_decoder.sv
register_file.sv
branch_unit.sv
id_pipe_regs.sv
id_stage.sv
tb_id_stage.sv

// ==== id_stage.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module id_stage
   import id_pkg::*;
   (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_valid,
   input  logic [`ID_NB_REG-1:0]          i_instruction,
   input  logic [`ID_NB_REG-1:0]          i_pc,
   input  logic [`ID_NB_REG_ADDR-1:0]     i_regfile_addr,
   input  logic [`ID_NB_REG-1:0]          i_regfile_data,
   input  logic                           i_regfile_we,
   input  logic                           i_sc_muxa,
   input  logic                           i_sc_muxb,
   input  logic [`ID_NB_REG-1:0]          i_sc_dataa,
   input  logic [`ID_NB_REG-1:0]          i_sc_datab,
   output logic [$bits(mem_ctrl_t)-1:0]   o_mem_ctrl,
   output logic [$bits(ex_ctrl_t)-1:0]    o_ex_ctrl,
   output logic [$bits(wb_ctrl_t)-1:0]    o_wb_ctrl,
   output logic [`ID_NB_REG-1:0]          o_pc,
   output logic [`ID_NB_REG-1:0]          o_a,
   output logic [`ID_NB_REG-1:0]          o_b,
   output logic [`ID_NB_INM-1:0]          o_inm,
   output logic [`ID_NB_SHAMT-1:0]        o_shamt,
   output logic                           o_nop,
   output logic                           o_branch,
   output logic                           o_branch_result,
   output logic                           o_jump_rs,
   output logic [`ID_NB_REG-1:0]          o_jump_rs_addr,
   output logic                           o_jump_inm,
   output logic [`ID_NB_J_INM-1:0]        o_jump_inm_addr,
   output logic                           o_rinst,
   output logic                           o_store,
   output logic                           o_run
   );

   logic                  valid;
   logic                  squash;
   logic [`ID_NB_REG-1:0] rdata_a;
   logic [`ID_NB_REG-1:0] rdata_b;

   id_ctrl_if ctrl_bus (.i_clk(i_clk));

   main_decoder u_main_decoder (
      .i_instruction (i_instruction),
      .i_valid       (i_valid),
      .ctrl          (ctrl_bus),
      .o_valid       (valid)
   );

   // Writes are dropped while the stage is frozen
   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_regfile_we & valid),
      .i_waddr   (i_regfile_addr),
      .i_wdata   (i_regfile_data),
      .i_raddr_a (i_instruction[`ID_MSB_RS -: `ID_NB_REG_ADDR]),
      .i_raddr_b (i_instruction[`ID_MSB_RT -: `ID_NB_REG_ADDR]),
      .o_rdata_a (rdata_a),
      .o_rdata_b (rdata_b)
   );

   branch_unit u_branch_unit (
      .i_rdata_a      (rdata_a),
      .i_rdata_b      (rdata_b),
      .i_fwd_sel_a    (i_sc_muxa),
      .i_fwd_data_a   (i_sc_dataa),
      .i_fwd_sel_b    (i_sc_muxb),
      .i_fwd_data_b   (i_sc_datab),
      .i_is_branch    (ctrl_bus.is_branch),
      .i_branch_ne    (ctrl_bus.branch_ne),
      .i_jump_rs      (ctrl_bus.jump_rs),
      .i_jump_inm     (ctrl_bus.jump_inm),
      .o_branch_taken (o_branch_result),
      .o_squash       (squash)
   );

   id_pipe_regs u_id_pipe_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_valid    (valid),
      .ctrl       (ctrl_bus),
      .i_squash   (squash),
      .i_a        (rdata_a),
      .i_b        (rdata_b),
      .i_pc       (i_pc),
      .i_inm      (i_instruction[`ID_MSB_INM -: `ID_NB_INM]),
      .i_shamt    (i_instruction[`ID_MSB_SHAMT -: `ID_NB_SHAMT]),
      .o_ex_ctrl  (o_ex_ctrl),
      .o_mem_ctrl (o_mem_ctrl),
      .o_wb_ctrl  (o_wb_ctrl),
      .o_a        (o_a),
      .o_b        (o_b),
      .o_pc       (o_pc),
      .o_inm      (o_inm),
      .o_shamt    (o_shamt),
      .o_nop      (o_nop)
   );

   // Same-cycle flags for fetch and hazard logic
   assign o_branch        = ctrl_bus.is_branch;
   assign o_jump_rs       = ctrl_bus.jump_rs;
   assign o_jump_rs_addr  = rdata_a;
   assign o_jump_inm      = ctrl_bus.jump_inm;
   assign o_jump_inm_addr = i_instruction[`ID_NB_J_INM-1:0];
   assign o_rinst         = ctrl_bus.is_r_type;
   assign o_store         = ctrl_bus.mem.wr_en;
   assign o_run           = valid;

endmodule

// ==== main_decoder.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module main_decoder
   import id_pkg::*;
   (
   input  logic [`ID_NB_REG-1:0] i_instruction,
   input  logic                  i_valid,
   id_ctrl_if.dec                ctrl,
   output logic                  o_valid
   );

   opcode_e                    opcode;
   func_e                      func;
   logic [`ID_NB_REG_ADDR-1:0] rt;
   logic [`ID_NB_REG_ADDR-1:0] rd;
   logic [`ID_NB_REG_ADDR-1:0] dest;

   alu_op_e   alu_op_main;
   alu_op_e   fn_alu_op;
   logic      fn_use_shamt;
   logic      fn_link_pc;
   logic      fn_jump_rs;
   logic      imm_sel;
   logic      unsigned_imm;
   logic      rd_en;
   logic      wr_en;
   logic      unsigned_ld;
   mem_size_e size;
   logic      reg_we;
   logic      from_alu;
   logic      link_ra;
   logic      is_r_type;
   logic      is_branch;
   logic      branch_ne;
   logic      jump_inm;

   // Low opcode bits give the access width for loads and stores
   function automatic mem_size_e access_size(input logic [1:0] low);
      case (low)
         2'b00:   access_size = SZ_BYTE;
         2'b01:   access_size = SZ_HALF;
         default: access_size = SZ_WORD;
      endcase
   endfunction

   assign opcode = opcode_e'(i_instruction[`ID_MSB_OPCODE -: `ID_NB_OPCODE]);
   assign func   = func_e'(i_instruction[`ID_MSB_FUNC -: `ID_NB_OPCODE]);
   assign rt     = i_instruction[`ID_MSB_RT -: `ID_NB_REG_ADDR];
   assign rd     = i_instruction[`ID_MSB_RD -: `ID_NB_REG_ADDR];

   assign o_valid = i_valid & (opcode != HLT);

   func_decoder u_func_decoder (
      .i_func      (func),
      .o_alu_op    (fn_alu_op),
      .o_use_shamt (fn_use_shamt),
      .o_link_pc   (fn_link_pc),
      .o_jump_rs   (fn_jump_rs)
   );

   ////////////////////////////////////////////////////////////
   // Opcode table
   ////////////////////////////////////////////////////////////

   always_comb begin
      alu_op_main  = ADD;
      imm_sel      = 1'b0;
      unsigned_imm = 1'b0;
      rd_en        = 1'b0;
      wr_en        = 1'b0;
      unsigned_ld  = 1'b0;
      size         = SZ_BYTE;
      reg_we       = 1'b0;
      from_alu     = 1'b0;
      link_ra      = 1'b0;
      is_r_type    = 1'b0;
      is_branch    = 1'b0;
      branch_ne    = 1'b0;
      jump_inm     = 1'b0;
      case (opcode)
         R_INST: begin
            is_r_type = 1'b1;
            reg_we    = 1'b1;
            from_alu  = 1'b1;
         end
         LB, LH, LW, LBU, LHU, LWU: begin
            imm_sel     = 1'b1;
            rd_en       = 1'b1;
            reg_we      = 1'b1;
            unsigned_ld = opcode inside {LBU, LHU, LWU};
            size        = access_size(opcode[1:0]);
         end
         SB, SH, SW: begin
            imm_sel = 1'b1;
            wr_en   = 1'b1;
            size    = access_size(opcode[1:0]);
         end
         ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
            imm_sel      = 1'b1;
            unsigned_imm = opcode inside {ANDI, ORI, XORI, LUI};
            reg_we       = 1'b1;
            from_alu     = 1'b1;
            case (opcode)
               SLTI:    alu_op_main = SLT;
               ANDI:    alu_op_main = AND;
               ORI:     alu_op_main = OR;
               XORI:    alu_op_main = XOR;
               LUI:     alu_op_main = LUI_OP;
               default: alu_op_main = ADD;
            endcase
         end
         BEQ, BNE: begin
            imm_sel   = 1'b1;
            is_branch = 1'b1;
            branch_ne = (opcode == BNE);
         end
         J, JAL: begin
            jump_inm  = 1'b1;
            link_ra   = (opcode == JAL);
            reg_we    = (opcode == JAL);
         end
         default: begin
         end
      endcase
   end

   // Destination register and merge with the R-type table
   assign dest = link_ra ? `ID_RA_ADDR : (imm_sel ? rt : rd);

   assign ctrl.ex = '{alu_op:       is_r_type ? fn_alu_op : alu_op_main,
                      imm_sel:      imm_sel,
                      unsigned_imm: unsigned_imm,
                      use_shamt:    fn_use_shamt & is_r_type};
   assign ctrl.mem = '{rd_en:       rd_en,
                       wr_en:       wr_en,
                       unsigned_ld: unsigned_ld,
                       size:        size};
   assign ctrl.wb = '{dest:     dest,
                      reg_we:   reg_we & (dest != '0),
                      from_alu: from_alu,
                      link_pc:  is_r_type ? fn_link_pc : link_ra};

   assign ctrl.is_r_type = is_r_type;
   assign ctrl.is_branch = is_branch;
   assign ctrl.branch_ne = branch_ne;
   assign ctrl.jump_rs   = fn_jump_rs & is_r_type;
   assign ctrl.jump_inm  = jump_inm;

   a_enc_defined: assert property (@(posedge ctrl.i_clk)
      !$isunknown(i_instruction) |->
         (ctrl.ex.alu_op <= LUI_OP) && (ctrl.mem.size inside {SZ_BYTE, SZ_HALF, SZ_WORD}))
      else $error("undefined ALU op or access size");

   a_rd_wr_excl: assert property (@(posedge ctrl.i_clk)
      !$isunknown(i_instruction) |-> !(ctrl.mem.rd_en && ctrl.mem.wr_en))
      else $error("memory read and write requested together");

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module register_file (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_we,
   input  logic [`ID_NB_REG_ADDR-1:0] i_waddr,
   input  logic [`ID_NB_REG-1:0]      i_wdata,
   input  logic [`ID_NB_REG_ADDR-1:0] i_raddr_a,
   input  logic [`ID_NB_REG_ADDR-1:0] i_raddr_b,
   output logic [`ID_NB_REG-1:0]      o_rdata_a,
   output logic [`ID_NB_REG-1:0]      o_rdata_b
);

   logic [`ID_NB_REG-1:0] regs [`ID_REG_DEPTH];

   // Falling edge write, so the value is readable before the next rising edge
   always_ff @(negedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `ID_REG_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

   // Write port comes from the WB stage
   a_waddr_known: assert property (@(negedge i_clk) disable iff (i_rst)
      i_we |-> !$isunknown(i_waddr))
      else $error("register file write with unknown address");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --top-module tb_id_stage -f id_stage.f > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_id_stage > sim.log 2>&1
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "simulation ok" \
   || { echo "simulation not ok"; exit 1; }

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id_stage;

   localparam int CLK_HALF   = 10;
   localparam int MAX_CYCLES = 2000;

   typedef struct {
      string       name;
      logic [31:0] instr;
      logic        valid;
      logic        fsel_a;
      logic [31:0] fdata_a;
      logic        fsel_b;
      logic [31:0] fdata_b;
      logic        we;
      logic [4:0]  waddr;
      logic [31:0] wdata;
      logic [6:0]  ex;
      logic [4:0]  mem;
      logic [7:0]  wb;
      logic        nop;
      // branch, branch_result, jump_rs, jump_inm, rinst, store, run
      logic [6:0]  flags;
   } row_t;

   logic        i_clk;
   logic        i_rst;
   logic        i_valid;
   logic [31:0] i_instruction;
   logic [31:0] i_pc;
   logic [4:0]  i_regfile_addr;
   logic [31:0] i_regfile_data;
   logic        i_regfile_we;
   logic        i_sc_muxa;
   logic        i_sc_muxb;
   logic [31:0] i_sc_dataa;
   logic [31:0] i_sc_datab;
   logic [4:0]  o_mem_ctrl;
   logic [6:0]  o_ex_ctrl;
   logic [7:0]  o_wb_ctrl;
   logic [31:0] o_pc;
   logic [31:0] o_a;
   logic [31:0] o_b;
   logic [15:0] o_inm;
   logic [4:0]  o_shamt;
   logic        o_nop;
   logic        o_branch;
   logic        o_branch_result;
   logic        o_jump_rs;
   logic [31:0] o_jump_rs_addr;
   logic        o_jump_inm;
   logic [25:0] o_jump_inm_addr;
   logic        o_rinst;
   logic        o_store;
   logic        o_run;

   row_t        table_q[$];
   logic [31:0] model [32];
   logic [15:0] lfsr_state = 16'd37271;
   int          errors = 0;
   int          checks = 0;
   logic [31:0] pc_count = 32'h0000_1000;
   // Pending forwarding and write for the next row
   logic        pend_fsel_a = 1'b0;
   logic        pend_fsel_b = 1'b0;
   logic [31:0] pend_fdata_a = '0;
   logic [31:0] pend_fdata_b = '0;
   logic        pend_we = 1'b0;
   logic [4:0]  pend_waddr = '0;
   logic [31:0] pend_wdata = '0;
   // Expected registered outputs hold while the stage is frozen
   logic [6:0]  exp_ex = '0;
   logic [4:0]  exp_mem = '0;
   logic [7:0]  exp_wb = '0;
   logic [31:0] exp_a = '0;
   logic [31:0] exp_b = '0;
   logic        exp_nop = 1'b0;

   id_stage UUT (
      .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid),
      .i_instruction(i_instruction), .i_pc(i_pc),
      .i_regfile_addr(i_regfile_addr), .i_regfile_data(i_regfile_data),
      .i_regfile_we(i_regfile_we),
      .i_sc_muxa(i_sc_muxa), .i_sc_muxb(i_sc_muxb),
      .i_sc_dataa(i_sc_dataa), .i_sc_datab(i_sc_datab),
      .o_mem_ctrl(o_mem_ctrl), .o_ex_ctrl(o_ex_ctrl), .o_wb_ctrl(o_wb_ctrl),
      .o_pc(o_pc), .o_a(o_a), .o_b(o_b), .o_inm(o_inm), .o_shamt(o_shamt),
      .o_nop(o_nop), .o_branch(o_branch), .o_branch_result(o_branch_result),
      .o_jump_rs(o_jump_rs), .o_jump_rs_addr(o_jump_rs_addr),
      .o_jump_inm(o_jump_inm), .o_jump_inm_addr(o_jump_inm_addr),
      .o_rinst(o_rinst), .o_store(o_store), .o_run(o_run)
   );

   initial begin
      i_clk = 1'b0;
      forever #CLK_HALF i_clk = ~i_clk;
   end

   // Watchdog
   initial begin
      for (int c = 0; c < MAX_CYCLES; c++) begin
         @(posedge i_clk);
      end
      $display("timeout: simulation ran past the cycle limit");
      $display("TESTBENCH FAILED");
      $finish;
   end

   // Galois LFSR stepped once per bit
   function logic lfsr_step();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 16'hB400;
      return b;
   endfunction

   function logic [31:0] lfsr_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w = {w[30:0], lfsr_step()};
      end
      return w;
   endfunction

   function automatic logic [31:0] r_op(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [4:0] sh,
                                        input logic [5:0] fn);
      return {6'd0, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic set_fwd(input logic sa, input logic [31:0] da,
                          input logic sb, input logic [31:0] db);
      pend_fsel_a  = sa;
      pend_fdata_a = da;
      pend_fsel_b  = sb;
      pend_fdata_b = db;
   endtask

   task automatic set_write(input logic [4:0] addr, input logic [31:0] data);
      pend_we    = 1'b1;
      pend_waddr = addr;
      pend_wdata = data;
   endtask

   task automatic add_row(input string name, input logic [31:0] instr, input logic valid,
                          input logic [6:0] ex, input logic [4:0] mem, input logic [7:0] wb,
                          input logic nop, input logic [6:0] flags);
      row_t r;
      r = '{name, instr, valid, pend_fsel_a, pend_fdata_a, pend_fsel_b, pend_fdata_b,
            pend_we, pend_waddr, pend_wdata, ex, mem, wb, nop, flags};
      table_q.push_back(r);
      set_fwd(1'b0, '0, 1'b0, '0);
      pend_we = 1'b0;
   endtask

   task automatic check_val(input string test, input string field,
                            input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         errors++;
         $display("mismatch %s %s expected %h actual %h", test, field, exp, act);
      end
   endtask

   task automatic run_row(input row_t r);
      logic       term;
      logic [4:0] rs;
      logic [4:0] rt;
      @(negedge i_clk);
      i_instruction  <= r.instr;
      i_valid        <= r.valid;
      i_pc           <= pc_count;
      i_sc_muxa      <= r.fsel_a;
      i_sc_dataa     <= r.fdata_a;
      i_sc_muxb      <= r.fsel_b;
      i_sc_datab     <= r.fdata_b;
      i_regfile_we   <= r.we;
      i_regfile_addr <= r.waddr;
      i_regfile_data <= r.wdata;
      term = r.valid && (r.instr[31:26] != 6'h3f);
      rs   = r.instr[25:21];
      rt   = r.instr[20:16];
      if (term) begin
         exp_ex  = r.ex;
         exp_mem = r.mem;
         exp_wb  = r.wb;
         exp_nop = r.nop;
         exp_a   = model[rs];
         exp_b   = model[rt];
      end
      #5;
      check_val(r.name, "flags", 32'(r.flags), 32'({o_branch, o_branch_result, o_jump_rs,
                o_jump_inm, o_rinst, o_store, o_run}));
      if (r.flags[4]) check_val(r.name, "jump_rs_addr", model[rs], o_jump_rs_addr);
      if (r.flags[3]) check_val(r.name, "jump_inm_addr", 32'(r.instr[25:0]),
                                32'(o_jump_inm_addr));
      @(posedge i_clk);
      #1;
      check_val(r.name, "ex_ctrl", 32'(exp_ex), 32'(o_ex_ctrl));
      check_val(r.name, "mem_ctrl", 32'(exp_mem), 32'(o_mem_ctrl));
      check_val(r.name, "wb_ctrl", 32'(exp_wb), 32'(o_wb_ctrl));
      check_val(r.name, "a", exp_a, o_a);
      check_val(r.name, "b", exp_b, o_b);
      check_val(r.name, "nop", 32'(exp_nop), 32'(o_nop));
      check_val(r.name, "pc", pc_count, o_pc);
      check_val(r.name, "inm", 32'(r.instr[15:0]), 32'(o_inm));
      check_val(r.name, "shamt", 32'(r.instr[10:6]), 32'(o_shamt));
      // Write lands on the coming falling edge
      if (term && r.we && r.waddr != 5'd0) model[r.waddr] = r.wdata;
      pc_count = pc_count + 32'd4;
   endtask

   task automatic wait_reset_clear();
      int  n;
      logic clear;
      clear = 1'b0;
      for (n = 0; n < 10 && !clear; n++) begin
         @(posedge i_clk);
         #1;
         clear = (o_ex_ctrl == '0) && (o_mem_ctrl == '0) && (o_wb_ctrl == '0) &&
                 (o_a == '0) && (o_b == '0) && !o_nop && (o_pc == '0) &&
                 (o_inm == '0) && (o_shamt == '0);
      end
      checks++;
      assert (clear) else begin
         errors++;
         $display("registered outputs did not clear during reset");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////

   task automatic build_table();
      add_row("addu", r_op(5'd1, 5'd2, 5'd3, 5'd0, 6'h21), 1'b1, 7'h00, 5'h00, 8'h1E, 1'b0, 7'h05);
      add_row("subu", r_op(5'd1, 5'd2, 5'd4, 5'd0, 6'h23), 1'b1, 7'h08, 5'h00, 8'h26, 1'b0, 7'h05);
      add_row("and", r_op(5'd2, 5'd3, 5'd5, 5'd0, 6'h24), 1'b1, 7'h10, 5'h00, 8'h2E, 1'b0, 7'h05);
      add_row("or", r_op(5'd4, 5'd5, 5'd6, 5'd0, 6'h25), 1'b1, 7'h18, 5'h00, 8'h36, 1'b0, 7'h05);
      add_row("xor", r_op(5'd6, 5'd7, 5'd7, 5'd0, 6'h26), 1'b1, 7'h20, 5'h00, 8'h3E, 1'b0, 7'h05);
      add_row("nor", r_op(5'd8, 5'd9, 5'd8, 5'd0, 6'h27), 1'b1, 7'h28, 5'h00, 8'h46, 1'b0, 7'h05);
      add_row("slt", r_op(5'd10, 5'd11, 5'd9, 5'd0, 6'h2A), 1'b1, 7'h50, 5'h00, 8'h4E, 1'b0, 7'h05);
      add_row("sll", r_op(5'd0, 5'd12, 5'd10, 5'd4, 6'h00), 1'b1, 7'h39, 5'h00, 8'h56, 1'b0, 7'h05);
      add_row("srl", r_op(5'd0, 5'd13, 5'd11, 5'd7, 6'h02), 1'b1, 7'h31, 5'h00, 8'h5E, 1'b0, 7'h05);
      add_row("sra", r_op(5'd0, 5'd14, 5'd12, 5'd9, 6'h03), 1'b1, 7'h41, 5'h00, 8'h66, 1'b0, 7'h05);
      add_row("sllv", r_op(5'd15, 5'd16, 5'd13, 5'd0, 6'h04), 1'b1, 7'h38, 5'h00, 8'h6E, 1'b0, 7'h05);
      add_row("srlv", r_op(5'd17, 5'd18, 5'd14, 5'd0, 6'h06), 1'b1, 7'h30, 5'h00, 8'h76, 1'b0, 7'h05);
      add_row("srav", r_op(5'd19, 5'd20, 5'd15, 5'd0, 6'h07), 1'b1, 7'h40, 5'h00, 8'h7E, 1'b0, 7'h05);
      add_row("addu_r0", r_op(5'd1, 5'd2, 5'd0, 5'd0, 6'h21), 1'b1, 7'h00, 5'h00, 8'h02, 1'b0, 7'h05);
      add_row("jr", r_op(5'd6, 5'd0, 5'd0, 5'd0, 6'h08), 1'b1, 7'h00, 5'h00, 8'h02, 1'b1, 7'h15);
      add_row("jalr", r_op(5'd7, 5'd0, 5'd31, 5'd0, 6'h09), 1'b1, 7'h00, 5'h00, 8'hFF, 1'b1, 7'h15);
      add_row("lb", i_op(6'h20, 5'd1, 5'd16, 16'h0010), 1'b1, 7'h04, 5'h10, 8'h84, 1'b0, 7'h01);
      add_row("lh", i_op(6'h21, 5'd2, 5'd17, 16'h0022), 1'b1, 7'h04, 5'h11, 8'h8C, 1'b0, 7'h01);
      add_row("lw", i_op(6'h23, 5'd3, 5'd18, 16'h0044), 1'b1, 7'h04, 5'h12, 8'h94, 1'b0, 7'h01);
      add_row("lbu", i_op(6'h24, 5'd4, 5'd19, 16'h8001), 1'b1, 7'h04, 5'h14, 8'h9C, 1'b0, 7'h01);
      add_row("lhu", i_op(6'h25, 5'd5, 5'd20, 16'hFFFE), 1'b1, 7'h04, 5'h15, 8'hA4, 1'b0, 7'h01);
      add_row("lwu", i_op(6'h27, 5'd6, 5'd21, 16'h0100), 1'b1, 7'h04, 5'h16, 8'hAC, 1'b0, 7'h01);
      add_row("sb", i_op(6'h28, 5'd7, 5'd22, 16'h0003), 1'b1, 7'h04, 5'h08, 8'hB0, 1'b0, 7'h03);
      add_row("sh", i_op(6'h29, 5'd8, 5'd23, 16'h0006), 1'b1, 7'h04, 5'h09, 8'hB8, 1'b0, 7'h03);
      add_row("sw", i_op(6'h2B, 5'd9, 5'd24, 16'h000C), 1'b1, 7'h04, 5'h0A, 8'hC0, 1'b0, 7'h03);
      add_row("addi", i_op(6'h09, 5'd10, 5'd25, 16'h7FFF), 1'b1, 7'h04, 5'h00, 8'hCE, 1'b0, 7'h01);
      add_row("andi", i_op(6'h0C, 5'd11, 5'd26, 16'h00FF), 1'b1, 7'h16, 5'h00, 8'hD6, 1'b0, 7'h01);
      add_row("ori", i_op(6'h0D, 5'd12, 5'd27, 16'hF0F0), 1'b1, 7'h1E, 5'h00, 8'hDE, 1'b0, 7'h01);
      add_row("xori", i_op(6'h0E, 5'd13, 5'd28, 16'h5A5A), 1'b1, 7'h26, 5'h00, 8'hE6, 1'b0, 7'h01);
      add_row("lui", i_op(6'h0F, 5'd0, 5'd29, 16'h1234), 1'b1, 7'h5E, 5'h00, 8'hEE, 1'b0, 7'h01);
      add_row("slti", i_op(6'h0A, 5'd14, 5'd30, 16'hFF00), 1'b1, 7'h54, 5'h00, 8'hF6, 1'b0, 7'h01);
      add_row("addi_r0", i_op(6'h09, 5'd1, 5'd0, 16'h0001), 1'b1, 7'h04, 5'h00, 8'h02, 1'b0, 7'h01);
      add_row("j", {6'h02, 26'h0000400}, 1'b1, 7'h00, 5'h00, 8'h00, 1'b1, 7'h09);
      add_row("jal", {6'h03, 26'h0000400}, 1'b1, 7'h00, 5'h00, 8'hFD, 1'b1, 7'h09);
      add_row("beq_eq", i_op(6'h04, 5'd3, 5'd3, 16'h0008), 1'b1, 7'h04, 5'h00, 8'h18, 1'b1, 7'h61);
      add_row("bne_eq", i_op(6'h05, 5'd3, 5'd3, 16'h0008), 1'b1, 7'h04, 5'h00, 8'h18, 1'b0, 7'h41);
      set_write(5'd5, 32'h0000_1234);
      add_row("nop_wr", 32'h0, 1'b1, 7'h39, 5'h00, 8'h02, 1'b0, 7'h05);
      add_row("rd_after_wr", r_op(5'd5, 5'd5, 5'd1, 5'd0, 6'h21), 1'b1, 7'h00, 5'h00, 8'h0E,
              1'b0, 7'h05);
      add_row("beq_ne", i_op(6'h04, 5'd0, 5'd5, 16'h0004), 1'b1, 7'h04, 5'h00, 8'h28, 1'b0, 7'h41);
      add_row("bne_ne", i_op(6'h05, 5'd0, 5'd5, 16'h0004), 1'b1, 7'h04, 5'h00, 8'h28, 1'b1, 7'h61);
      set_fwd(1'b1, 32'h55, 1'b1, 32'h55);
      add_row("beq_fwd", i_op(6'h04, 5'd0, 5'd5, 16'h0004), 1'b1, 7'h04, 5'h00, 8'h28, 1'b1, 7'h61);
      set_fwd(1'b1, 32'h1, 1'b1, 32'h2);
      add_row("bne_fwd", i_op(6'h05, 5'd3, 5'd3, 16'h0004), 1'b1, 7'h04, 5'h00, 8'h18, 1'b1, 7'h61);
      // Writes must be dropped while the stage is frozen
      set_write(5'd6, 32'hDEAD_BEEF);
      add_row("hlt", 32'hFC00_0000, 1'b1, 7'h00, 5'h00, 8'h00, 1'b0, 7'h00);
      set_write(5'd7, 32'hCAFE_F00D);
      add_row("invalid", r_op(5'd6, 5'd7, 5'd2, 5'd0, 6'h21), 1'b0, 7'h00, 5'h00, 8'h16,
              1'b0, 7'h04);
      add_row("after_freeze", r_op(5'd6, 5'd7, 5'd2, 5'd0, 6'h21), 1'b1, 7'h00, 5'h00, 8'h16,
              1'b0, 7'h05);
   endtask

   initial begin
      i_rst          = 1'b1;
      i_valid        = 1'b1;
      i_instruction  = '0;
      i_pc           = '0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      i_regfile_we   = 1'b0;
      i_sc_muxa      = 1'b0;
      i_sc_muxb      = 1'b0;
      i_sc_dataa     = '0;
      i_sc_datab     = '0;
      for (int i = 0; i < 32; i++) begin
         model[i] = '0;
      end
      build_table();
      wait_reset_clear();
      @(posedge i_clk);
      @(negedge i_clk);
      i_rst <= 1'b0;
      // Fill registers 1 to 31
      for (int r = 1; r < 32; r++) begin
         @(negedge i_clk);
         model[r] = lfsr_word();
         i_regfile_we   <= 1'b1;
         i_regfile_addr <= 5'(r);
         i_regfile_data <= model[r];
      end
      foreach (table_q[k]) begin
         run_row(table_q[k]);
      end
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
